//--- design/dm_consts.svh
`ifndef DM_CONSTS_SVH
`define DM_CONSTS_SVH

// buffer sizes, abstractauto layout depends on these
`define DM_DATA_COUNT     2
`define DM_PROGBUF_SIZE   8

// dmi address map
`define DM_ADDR_DATA0        7'h04
`define DM_ADDR_DMCONTROL    7'h10
`define DM_ADDR_DMSTATUS     7'h11
`define DM_ADDR_ABSTRACTCS   7'h16
`define DM_ADDR_COMMAND      7'h17
`define DM_ADDR_ABSTRACTAUTO 7'h18
`define DM_ADDR_PROGBUF0     7'h20

`define DM_OP_NOP     2'd0
`define DM_OP_READ    2'd1
`define DM_OP_WRITE   2'd2
`define DM_ST_SUCCESS 2'd0
`define DM_ST_BUSY    2'd3

`define DM_CMDERR_NONE 3'd0
`define DM_CMDERR_BUSY 3'd1

`define DM_VERSION 4'd2  // spec 0.13

`endif

//--- design/dm_csr_regs.sv
`include "dm_consts.svh"

module dm_csr_regs (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               acc_i,
  input  dm_pkg::csr_req_t                   req_i,
  input  logic                               halted_i,
  input  logic                               unavailable_i,
  input  logic                               resumeack_i,
  input  logic                               cmdbusy_i,
  input  logic                               cmderror_valid_i,
  input  logic [2:0]                         cmderror_i,
  input  logic                               data_valid_i,
  input  logic [`DM_DATA_COUNT-1:0][31:0]    data_i,
  output logic                               push_o,
  output dm_pkg::dmi_resp_t                  resp_o,
  output logic                               haltreq_o,
  output logic                               resumereq_o,
  output logic                               clear_resumeack_o,
  output logic                               ndmreset_o,
  output logic                               dmactive_o,
  output logic                               cmd_valid_o,
  output logic [31:0]                        cmd_o,
  output logic [`DM_PROGBUF_SIZE-1:0][31:0]  progbuf_o,
  output logic [`DM_DATA_COUNT-1:0][31:0]    data_o
);

  localparam int data_idx_w = $clog2(`DM_DATA_COUNT);
  localparam int prog_idx_w = $clog2(`DM_PROGBUF_SIZE);

  logic haltreq_q, haltreq_d;
  logic resumereq_q, resumereq_d;
  logic ndmreset_q, ndmreset_d;
  logic dmactive_q, dmactive_d;
  logic havereset_q, havereset_d;
  logic cmd_valid_q, cmd_valid_d;
  logic [2:0] cmderr_q, cmderr_d;
  logic [`DM_DATA_COUNT-1:0]   autoexec_data_q, autoexec_data_d;
  logic [`DM_PROGBUF_SIZE-1:0] autoexec_prog_q, autoexec_prog_d;
  logic [31:0]                       command_q;
  logic [`DM_DATA_COUNT-1:0][31:0]   data_q;
  logic [`DM_PROGBUF_SIZE-1:0][31:0] progbuf_q;

  logic [31:0]      dmstatus;
  dm_pkg::dm_word_u rdata;
  logic rd, wr, wr_ok, busy, busy_hit, autoexec_hit;
  logic [data_idx_w-1:0] data_idx;
  logic [prog_idx_w-1:0] prog_idx;

  assign rd       = acc_i & req_i.read;
  assign wr       = acc_i & req_i.write;
  assign wr_ok    = wr & ~busy_hit;
  assign data_idx = req_i.index[data_idx_w-1:0];
  assign prog_idx = req_i.index[prog_idx_w-1:0];
  assign busy     = cmdbusy_i | cmd_valid_q;  // a just issued command is in flight

  // busy rule and autoexec lookup
  always_comb begin
    busy_hit     = 1'b0;
    autoexec_hit = 1'b0;
    case (req_i.sel)
      dm_pkg::sel_data: begin
        busy_hit     = (rd | wr) & busy;
        autoexec_hit = autoexec_data_q[data_idx];
      end
      dm_pkg::sel_progbuf: begin
        busy_hit     = (rd | wr) & busy;
        autoexec_hit = autoexec_prog_q[prog_idx];
      end
      dm_pkg::sel_command, dm_pkg::sel_abstractcs, dm_pkg::sel_abstractauto:
        busy_hit = wr & busy;
      default: ;
    endcase
  end

  always_comb begin
    dmstatus        = '0;
    dmstatus[3:0]   = `DM_VERSION;
    dmstatus[7]     = 1'b1;  // authenticated
    dmstatus[9:8]   = {2{halted_i & ~unavailable_i}};
    dmstatus[11:10] = {2{~halted_i & ~unavailable_i}};
    dmstatus[13:12] = {2{unavailable_i}};
    dmstatus[17:16] = {2{resumeack_i}};
    dmstatus[19:18] = {2{havereset_q}};
  end

  // read mux, command reads zero
  always_comb begin
    rdata.raw = '0;
    case (req_i.sel)
      dm_pkg::sel_data:     rdata.raw = data_q[data_idx];
      dm_pkg::sel_progbuf:  rdata.raw = progbuf_q[prog_idx];
      dm_pkg::sel_dmstatus: rdata.raw = dmstatus;
      dm_pkg::sel_dmcontrol: begin
        rdata.dmcontrol.haltreq   = haltreq_q;
        rdata.dmcontrol.resumereq = resumereq_q;
        rdata.dmcontrol.ndmreset  = ndmreset_q;
        rdata.dmcontrol.dmactive  = dmactive_q;
      end
      dm_pkg::sel_abstractcs: begin
        rdata.abstractcs.progbufsize = 5'(`DM_PROGBUF_SIZE);
        rdata.abstractcs.busy        = busy;
        rdata.abstractcs.cmderr      = cmderr_q;
        rdata.abstractcs.datacount   = 4'(`DM_DATA_COUNT);
      end
      dm_pkg::sel_abstractauto: begin
        rdata.raw[`DM_DATA_COUNT-1:0]     = autoexec_data_q;
        rdata.raw[16 +: `DM_PROGBUF_SIZE] = autoexec_prog_q;
      end
      default: ;
    endcase
  end

  assign push_o      = acc_i;  // one response per accepted request
  assign resp_o.data = (rd & ~busy_hit) ? rdata.raw : 32'h0;
  assign resp_o.resp = busy_hit ? `DM_ST_BUSY : `DM_ST_SUCCESS;

  always_comb begin
    haltreq_d         = haltreq_q;
    resumereq_d       = resumereq_q;
    ndmreset_d        = ndmreset_q;
    dmactive_d        = dmactive_q;
    havereset_d       = havereset_q;
    cmderr_d          = cmderr_q;
    autoexec_data_d   = autoexec_data_q;
    autoexec_prog_d   = autoexec_prog_q;
    clear_resumeack_o = 1'b0;
    if (wr && req_i.sel == dm_pkg::sel_dmcontrol) begin
      haltreq_d         = req_i.wdata.dmcontrol.haltreq;
      resumereq_d       = req_i.wdata.dmcontrol.resumereq;
      ndmreset_d        = req_i.wdata.dmcontrol.ndmreset;
      dmactive_d        = req_i.wdata.dmcontrol.dmactive;
      clear_resumeack_o = dmactive_q & req_i.wdata.dmcontrol.resumereq & ~resumereq_q;
      if (req_i.wdata.dmcontrol.ackhavereset) begin
        havereset_d = 1'b0;
      end
    end
    if (resumereq_q && resumeack_i) begin
      resumereq_d = 1'b0;  // hart has resumed
    end
    if (ndmreset_q) begin
      havereset_d = 1'b1;
    end
    if (busy_hit && cmderr_q == `DM_CMDERR_NONE) begin
      cmderr_d = `DM_CMDERR_BUSY;
    end else if (wr_ok && req_i.sel == dm_pkg::sel_abstractcs) begin
      cmderr_d = cmderr_q & ~req_i.wdata.abstractcs.cmderr;  // write 1 to clear
    end
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (wr_ok && req_i.sel == dm_pkg::sel_abstractauto) begin
      autoexec_data_d = req_i.wdata.raw[`DM_DATA_COUNT-1:0];
      autoexec_prog_d = req_i.wdata.raw[16 +: `DM_PROGBUF_SIZE];
    end
    cmd_valid_d = dmactive_q & ~busy_hit &
                  ((wr && req_i.sel == dm_pkg::sel_command) | ((rd | wr) & autoexec_hit));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      haltreq_q       <= 1'b0;
      resumereq_q     <= 1'b0;
      ndmreset_q      <= 1'b0;
      dmactive_q      <= 1'b0;
      havereset_q     <= 1'b1;  // hart comes out of reset
      cmd_valid_q     <= 1'b0;
      cmderr_q        <= `DM_CMDERR_NONE;
      autoexec_data_q <= '0;
      autoexec_prog_q <= '0;
    end else begin
      havereset_q <= havereset_d;
      dmactive_q  <= dmactive_d;
      if (!dmactive_q) begin
        // inactive module holds its state cleared
        haltreq_q       <= 1'b0;
        resumereq_q     <= 1'b0;
        ndmreset_q      <= 1'b0;
        cmd_valid_q     <= 1'b0;
        cmderr_q        <= `DM_CMDERR_NONE;
        autoexec_data_q <= '0;
        autoexec_prog_q <= '0;
      end else begin
        haltreq_q       <= haltreq_d;
        resumereq_q     <= resumereq_d;
        ndmreset_q      <= ndmreset_d;
        cmd_valid_q     <= cmd_valid_d;
        cmderr_q        <= cmderr_d;
        autoexec_data_q <= autoexec_data_d;
        autoexec_prog_q <= autoexec_prog_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!dmactive_q) begin
      command_q <= '0;
      data_q    <= '0;
      progbuf_q <= '0;
    end else begin
      if (wr_ok && req_i.sel == dm_pkg::sel_command) begin
        command_q <= req_i.wdata.raw;
      end
      if (wr_ok && req_i.sel == dm_pkg::sel_progbuf) begin
        progbuf_q[prog_idx] <= req_i.wdata.raw;
      end
      if (data_valid_i) begin
        data_q <= data_i;  // core writes back results
      end else if (wr_ok && req_i.sel == dm_pkg::sel_data) begin
        data_q[data_idx] <= req_i.wdata.raw;
      end
    end
  end

  assign haltreq_o   = haltreq_q;
  assign resumereq_o = resumereq_q;
  assign ndmreset_o  = ndmreset_q;
  assign dmactive_o  = dmactive_q;
  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign progbuf_o   = progbuf_q;
  assign data_o      = data_q;

  cmd_pulse_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cmd_valid_o |=> !cmd_valid_o)
    else $error("cmd_valid_o high for two cycles");

endmodule

//--- design/dm_pkg.sv
package dm_pkg;

  // host request word
  typedef struct packed {
    logic [6:0]  addr;
    logic [31:0] data;
    logic [1:0]  op;
  } dmi_req_t;

  // host response word
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;  // status code
  } dmi_resp_t;

  typedef enum logic [2:0] {
    sel_none,
    sel_data,
    sel_progbuf,
    sel_dmcontrol,
    sel_dmstatus,
    sel_abstractcs,
    sel_command,
    sel_abstractauto
  } csr_sel_e;

  typedef struct packed {
    logic        haltreq;
    logic        resumereq;
    logic        hartreset;
    logic        ackhavereset;
    logic [23:0] zero;  // hasel and hartsel, single hart
    logic        setresethaltreq;
    logic        clrresethaltreq;
    logic        ndmreset;
    logic        dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [2:0]  zero3;
    logic [4:0]  progbufsize;
    logic [10:0] zero2;
    logic        busy;
    logic        zero1;
    logic [2:0]  cmderr;
    logic [3:0]  zero0;
    logic [3:0]  datacount;
  } abstractcs_t;

  // one dmi word, seen per target register
  typedef union packed {
    dmcontrol_t  dmcontrol;
    abstractcs_t abstractcs;
    logic [31:0] raw;
  } dm_word_u;

  typedef struct packed {
    logic     read;
    logic     write;
    csr_sel_e sel;
    logic [2:0] index;  // word within data or progbuf
    dm_word_u wdata;
  } csr_req_t;

endpackage

//--- design/dm_req_decode.sv
`include "dm_consts.svh"

module dm_req_decode (
  input  logic             clk_i,
  input  logic             dmi_req_valid_i,
  input  dm_pkg::dmi_req_t dmi_req_i,
  input  logic             space_i,
  output logic             dmi_req_ready_o,
  output logic             acc_o,
  output dm_pkg::csr_req_t req_o
);

  logic [6:0] addr;
  logic [6:0] data_off;
  logic [6:0] prog_off;
  logic       in_data;
  logic       in_prog;

  assign addr     = dmi_req_i.addr;
  assign data_off = addr - `DM_ADDR_DATA0;
  assign prog_off = addr - `DM_ADDR_PROGBUF0;
  assign in_data  = (addr >= `DM_ADDR_DATA0) && (data_off < `DM_DATA_COUNT);
  assign in_prog  = (addr >= `DM_ADDR_PROGBUF0) && (prog_off < `DM_PROGBUF_SIZE);

  // accept only with room for the response
  assign dmi_req_ready_o = space_i;
  assign acc_o           = dmi_req_valid_i & space_i;

  always_comb begin
    req_o.read      = (dmi_req_i.op == `DM_OP_READ);
    req_o.write     = (dmi_req_i.op == `DM_OP_WRITE);
    req_o.index     = '0;
    req_o.wdata.raw = dmi_req_i.data;
    req_o.sel       = dm_pkg::sel_none;
    if (in_data) begin
      req_o.sel   = dm_pkg::sel_data;
      req_o.index = data_off[2:0];
    end else if (in_prog) begin
      req_o.sel   = dm_pkg::sel_progbuf;
      req_o.index = prog_off[2:0];
    end else begin
      case (addr)
        `DM_ADDR_DMCONTROL:    req_o.sel = dm_pkg::sel_dmcontrol;
        `DM_ADDR_DMSTATUS:     req_o.sel = dm_pkg::sel_dmstatus;
        `DM_ADDR_ABSTRACTCS:   req_o.sel = dm_pkg::sel_abstractcs;
        `DM_ADDR_COMMAND:      req_o.sel = dm_pkg::sel_command;
        `DM_ADDR_ABSTRACTAUTO: req_o.sel = dm_pkg::sel_abstractauto;
        default:               req_o.sel = dm_pkg::sel_none;  // unmapped reads as zero
      endcase
    end
  end

  // host keeps a stalled request unchanged
  req_held: assert property (@(posedge clk_i)
      dmi_req_valid_i && !dmi_req_ready_o |=> dmi_req_valid_i && $stable(dmi_req_i))
    else $error("dmi request changed while waiting for ready");

endmodule

//--- design/dm_resp_fifo.sv
module dm_resp_fifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_ni,
  input  logic              push_i,
  input  dm_pkg::dmi_resp_t data_i,
  output logic              space_o,
  output logic              dmi_resp_valid_o,
  input  logic              dmi_resp_ready_i,
  output dm_pkg::dmi_resp_t dmi_resp_o
);

  dm_pkg::dmi_resp_t mem [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       pop;

  assign pop              = dmi_resp_valid_o & dmi_resp_ready_i;
  assign space_o          = (count_q != 2'd2);
  assign dmi_resp_valid_o = (count_q != 2'd0);
  assign dmi_resp_o       = mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else if (!flush_ni) begin
      // host side reset drops queued responses
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push_i} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      push_i |-> count_q != 2'd2)
    else $error("response pushed into full queue");

endmodule

//--- design/dm_top.sv
`include "dm_consts.svh"

module dm_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               dmi_rst_ni,
  input  logic                               dmi_req_valid_i,
  input  dm_pkg::dmi_req_t                   dmi_req_i,
  output logic                               dmi_req_ready_o,
  output logic                               dmi_resp_valid_o,
  input  logic                               dmi_resp_ready_i,
  output dm_pkg::dmi_resp_t                  dmi_resp_o,
  // hart status
  input  logic                               halted_i,
  input  logic                               unavailable_i,
  input  logic                               resumeack_i,
  input  logic                               cmdbusy_i,
  input  logic                               cmderror_valid_i,
  input  logic [2:0]                         cmderror_i,
  input  logic                               data_valid_i,
  input  logic [`DM_DATA_COUNT-1:0][31:0]    data_i,
  // hart control
  output logic                               haltreq_o,
  output logic                               resumereq_o,
  output logic                               clear_resumeack_o,
  output logic                               ndmreset_o,
  output logic                               dmactive_o,
  output logic                               cmd_valid_o,
  output logic [31:0]                        cmd_o,
  output logic [`DM_PROGBUF_SIZE-1:0][31:0]  progbuf_o,
  output logic [`DM_DATA_COUNT-1:0][31:0]    data_o
);

  logic              space;
  logic              acc;
  logic              push;
  dm_pkg::csr_req_t  csr_req;
  dm_pkg::dmi_resp_t resp;

  dm_req_decode i_decode (
    .clk_i           (clk_i),
    .dmi_req_valid_i (dmi_req_valid_i),
    .dmi_req_i       (dmi_req_i),
    .space_i         (space),
    .dmi_req_ready_o (dmi_req_ready_o),
    .acc_o           (acc),
    .req_o           (csr_req)
  );

  dm_csr_regs i_regs (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .acc_i             (acc),
    .req_i             (csr_req),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .cmdbusy_i         (cmdbusy_i),
    .cmderror_valid_i  (cmderror_valid_i),
    .cmderror_i        (cmderror_i),
    .data_valid_i      (data_valid_i),
    .data_i            (data_i),
    .push_o            (push),
    .resp_o            (resp),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o),
    .cmd_valid_o       (cmd_valid_o),
    .cmd_o             (cmd_o),
    .progbuf_o         (progbuf_o),
    .data_o            (data_o)
  );

  dm_resp_fifo i_resp_fifo (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_ni         (dmi_rst_ni),
    .push_i           (push),
    .data_i           (resp),
    .space_o          (space),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_ready_i (dmi_resp_ready_i),
    .dmi_resp_o       (dmi_resp_o)
  );

endmodule

//--- run.sh
#!/bin/sh
# build and run the dm_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dm_top \
  -f verilog.f -o tb_dm_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_dm_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Verification passed$"; then
  exit 0
fi
exit 1

//--- sim/dm_input.txt
# halted cmdbusy resumeack resp_ready op addr wdata exp_status chk exp
# chk 0 read data, 1 cmd_o pulse, 2 clear_resumeack pulse, 3 {dmactive,resumereq,haltreq}
0 0 0 1 2 10 00000001 0 3 00000004
0 0 0 1 1 11 00000000 0 0 000c0c82
1 0 0 1 1 11 00000000 0 0 000c0382
0 0 0 1 2 10 10000001 0 0 00000000
0 0 0 1 1 11 00000000 0 0 00000c82
0 0 0 1 2 04 a5a50001 0 0 00000000
0 0 0 1 2 05 5a5a0002 0 0 00000000
0 0 0 1 2 27 77770007 0 0 00000000
0 0 0 1 1 04 00000000 0 0 a5a50001
0 0 0 1 1 05 00000000 0 0 5a5a0002
0 0 0 1 1 27 00000000 0 0 77770007
0 0 0 1 1 16 00000000 0 0 08000002
0 0 0 1 2 17 00231000 0 1 00231000
0 0 0 1 1 17 00000000 0 0 00000000
0 1 0 1 2 04 deadbeef 3 0 00000000
0 0 0 1 1 16 00000000 0 0 08000102
0 0 0 1 1 04 00000000 0 0 a5a50001
0 0 0 1 2 16 00000700 0 0 00000000
0 0 0 1 1 16 00000000 0 0 08000002
0 0 0 1 2 18 00000001 0 0 00000000
0 0 0 1 2 04 cafe0004 0 1 00231000
0 0 0 1 2 10 80000001 0 3 00000005
0 0 0 1 2 10 40000001 0 2 00000000
0 0 0 1 0 00 00000000 0 3 00000006
0 0 1 1 0 00 00000000 0 3 00000004
0 0 0 0 1 27 00000000 0 0 77770007
0 0 0 0 1 05 00000000 0 0 5a5a0002
0 0 0 1 1 11 00000000 0 0 00000c82

//--- sim/tb_dm_top.sv
`include "dm_consts.svh"

module tb_dm_top;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk_i;
  logic rst_ni;
  logic dmi_rst_n;
  logic req_valid;
  logic req_ready;
  logic resp_valid;
  logic resp_ready;
  dm_pkg::dmi_req_t  req;
  dm_pkg::dmi_resp_t resp;
  logic halted, unavailable, resumeack, cmdbusy;
  logic cmderror_valid, data_valid;
  logic [2:0] cmderror;
  logic [`DM_DATA_COUNT-1:0][31:0]   core_data;
  logic [`DM_DATA_COUNT-1:0][31:0]   data_out;
  logic [`DM_PROGBUF_SIZE-1:0][31:0] progbuf;
  logic haltreq, resumereq, clear_resumeack, ndmreset, dmactive, cmd_valid;
  logic [31:0] cmd;

  logic [33:0]       exp_q [$];  // {status, data} in request order
  dm_pkg::dmi_resp_t got_q [$];
  int errors, timeouts, cmd_pulses, clr_pulses;
  logic [31:0] last_cmd;

  dm_top DUT (
    .clk_i (clk_i), .rst_ni (rst_ni), .dmi_rst_ni (dmi_rst_n),
    .dmi_req_valid_i (req_valid), .dmi_req_i (req), .dmi_req_ready_o (req_ready),
    .dmi_resp_valid_o (resp_valid), .dmi_resp_ready_i (resp_ready), .dmi_resp_o (resp),
    .halted_i (halted), .unavailable_i (unavailable), .resumeack_i (resumeack),
    .cmdbusy_i (cmdbusy), .cmderror_valid_i (cmderror_valid), .cmderror_i (cmderror),
    .data_valid_i (data_valid), .data_i (core_data),
    .haltreq_o (haltreq), .resumereq_o (resumereq), .clear_resumeack_o (clear_resumeack),
    .ndmreset_o (ndmreset), .dmactive_o (dmactive), .cmd_valid_o (cmd_valid),
    .cmd_o (cmd), .progbuf_o (progbuf), .data_o (data_out)
  );

  always #20 clk_i = ~clk_i;

  // mid cycle sampling, pops land on the next rising edge
  always @(negedge clk_i) begin
    if (resp_valid && resp_ready) begin
      got_q.push_back(resp);
    end
    if (cmd_valid) begin
      cmd_pulses++;
      last_cmd = cmd;
    end
    if (clear_resumeack) clr_pulses++;
  end

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
    errors++;
  endtask

  // chk_v: 0 read data, 1 command pulse, 2 resumeack clear pulse, 3 control pins
  task automatic run_txn(input logic halted_v, input logic busy_v, input logic ack_v,
                         input logic rready_v, input logic [1:0] op_v,
                         input logic [6:0] addr_v, input logic [31:0] wdata_v,
                         input logic [1:0] st_v, input int chk_v, input logic [31:0] want_v);
    int n;
    dm_pkg::dmi_resp_t got;
    logic [33:0] want;
    @(posedge clk_i);
    halted     <= halted_v;
    cmdbusy    <= busy_v;
    resumeack  <= ack_v;
    resp_ready <= rready_v;
    req_valid  <= 1'b1;
    req        <= '{addr: addr_v, data: wdata_v, op: op_v};
    cmd_pulses = 0;
    clr_pulses = 0;
    @(negedge clk_i);
    if (exp_q.size() >= 2 && req_ready) begin
      report_mismatch("dmi_req_ready_o with full response queue", 32'(req_ready), 32'h0);
    end
    n = 0;
    while (!req_ready && n < 50) begin
      @(negedge clk_i);
      n++;
    end
    if (!req_ready) begin
      $display("timeout: request to address %h was never accepted", addr_v);
      timeouts++;
      @(posedge clk_i);
      req_valid <= 1'b0;
      return;
    end
    @(posedge clk_i);  // handshake edge
    req_valid <= 1'b0;
    exp_q.push_back({st_v, (chk_v == 0) ? want_v : 32'h0});
    if (!rready_v) return;  // response stays queued
    n = 0;
    while (got_q.size() < exp_q.size() && n < 50) begin
      @(posedge clk_i);
      n++;
    end
    if (got_q.size() < exp_q.size()) begin
      $display("timeout: response for address %h did not arrive", addr_v);
      timeouts++;
    end
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      got  = got_q.pop_front();
      want = exp_q.pop_front();
      if (got.resp !== want[33:32]) report_mismatch("response status", 32'(got.resp),
                                                    32'(want[33:32]));
      if (got.data !== want[31:0]) report_mismatch("response data", got.data, want[31:0]);
    end
    if (chk_v == 1 || chk_v == 2) begin
      n = 0;
      while (((chk_v == 1) ? cmd_pulses : clr_pulses) == 0 && n < 50) begin
        @(posedge clk_i);
        n++;
      end
      @(posedge clk_i);  // a stretched pulse would count twice
      if (((chk_v == 1) ? cmd_pulses : clr_pulses) == 0) begin
        $display("timeout: expected control pulse after address %h did not arrive", addr_v);
        timeouts++;
      end else if (chk_v == 1) begin
        if (cmd_pulses != 1) report_mismatch("cmd_valid_o cycles", cmd_pulses, 1);
        if (last_cmd !== want_v) report_mismatch("cmd_o", last_cmd, want_v);
      end else if (clr_pulses != 1) begin
        report_mismatch("clear_resumeack_o cycles", clr_pulses, 1);
      end
    end
    if (chk_v == 3) begin
      @(negedge clk_i);
      if ({dmactive, resumereq, haltreq} !== want_v[2:0]) begin
        report_mismatch("{dmactive, resumereq, haltreq}",
                        32'({dmactive, resumereq, haltreq}), want_v);
      end
    end
    if (chk_v == 0 && op_v == `DM_OP_READ && st_v == `DM_ST_SUCCESS) begin
      @(negedge clk_i);  // buffer ports carry the stored words
      if (addr_v >= `DM_ADDR_PROGBUF0 && addr_v < `DM_ADDR_PROGBUF0 + `DM_PROGBUF_SIZE) begin
        if (progbuf[addr_v - `DM_ADDR_PROGBUF0] !== want_v) begin
          report_mismatch("progbuf_o word", progbuf[addr_v - `DM_ADDR_PROGBUF0], want_v);
        end
      end else if (addr_v >= `DM_ADDR_DATA0 && addr_v < `DM_ADDR_DATA0 + `DM_DATA_COUNT) begin
        if (data_out[addr_v - `DM_ADDR_DATA0] !== want_v) begin
          report_mismatch("data_o word", data_out[addr_v - `DM_ADDR_DATA0], want_v);
        end
      end
    end
  endtask

  initial begin
    string line;
    int fd, n, chk;
    logic h, b, ack, rr;
    logic [1:0] op, st;
    logic [6:0] addr;
    logic [31:0] wdata, want;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    dmi_rst_n = 1'b1;
    req_valid = 1'b0;
    req = '0;
    resp_ready = 1'b1;
    halted = 1'b0;
    unavailable = 1'b0;
    resumeack = 1'b0;
    cmdbusy = 1'b0;
    cmderror_valid = 1'b0;
    cmderror = 3'd0;
    data_valid = 1'b0;
    core_data = '0;
    errors = 0;
    timeouts = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if ({req_ready, resp_valid} !== 2'b10) begin
      report_mismatch("{dmi_req_ready_o, dmi_resp_valid_o} after reset",
                      32'({req_ready, resp_valid}), 32'h2);
    end
    if ({cmd_valid, haltreq, resumereq, ndmreset, dmactive} !== 5'b0) begin
      report_mismatch("core controls after reset",
                      32'({cmd_valid, haltreq, resumereq, ndmreset, dmactive}), 32'h0);
    end
    fd = $fopen("sim/dm_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/dm_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %d %h",
                      h, b, ack, rr, op, addr, wdata, st, chk, want);
          if (n == 10) run_txn(h, b, ack, rr, op, addr, wdata, st, chk, want);
        end
      end
      $fclose(fd);
    end
    if (exp_q.size() != 0 || got_q.size() != 0) begin
      $display("responses left unmatched at the end of the run");
      errors++;
    end
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+design
design/dm_pkg.sv
design/dm_req_decode.sv
design/dm_csr_regs.sv
design/dm_resp_fifo.sv
design/dm_top.sv
sim/tb_dm_top.sv
